// File: src/bldc_pkg.sv
/* Shared BLDC driver types: phase command and hall status structs,
   motor mode enumeration and hall code constants */

package bldc_pkg;

    // ========================================================================
    // Constants
    // ========================================================================

    // Three phase motor, fixed by the hardware
    localparam int NUM_PHASES = 3;

    // Hall inputs have pull-ups, so a floating connector reads all high
    localparam logic [2:0] HALL_ALL_HIGH = 3'b111;
    // All lines pulled low points at a wiring or sensor supply fault
    localparam logic [2:0] HALL_ALL_LOW = 3'b000;

    // ========================================================================
    // Types
    // ========================================================================

    // Command for one phase; float_z overrides drive and turns both gates off
    typedef struct packed {
        logic drive;
        logic float_z;
    } phase_cmd_t;

    // Latched hall sensor conditions plus a strobe when a latch sets
    typedef struct packed {
        logic disconnected;
        logic hw_fault;
        logic fault_event;
    } hall_status_t;

    typedef enum logic [2:0] {
        MODE_STOP      = 3'd0,
        MODE_STARTUP   = 3'd1,
        MODE_RUN       = 3'd2,
        MODE_POLL_HALL = 3'd3,
        MODE_ERR       = 3'd4
    } motor_mode_e;

endpackage

// File: src/hall_commutation_decoder.sv
/* Six-step commutation decoder from hall code and direction */

`timescale 1ns/1ns

module hall_commutation_decoder (
    input  logic [2:0]                                   hall,
    input  logic                                         direction,
    output bldc_pkg::phase_cmd_t [bldc_pkg::NUM_PHASES-1:0] cmd
);

    // Phase indices for the high-side and low-side roles in forward rotation
    logic [1:0] fwd_high;
    logic [1:0] fwd_low;
    logic       code_valid;

    always_comb begin
        code_valid = 1'b1;
        fwd_high   = 2'd0;
        fwd_low    = 2'd1;
        // Standard 120 degree hall sequence; phase 0 is A, 1 is B, 2 is C
        case (hall)
            3'b101: begin fwd_high = 2'd0; fwd_low = 2'd1; end
            3'b100: begin fwd_high = 2'd0; fwd_low = 2'd2; end
            3'b110: begin fwd_high = 2'd1; fwd_low = 2'd2; end
            3'b010: begin fwd_high = 2'd1; fwd_low = 2'd0; end
            3'b011: begin fwd_high = 2'd2; fwd_low = 2'd0; end
            3'b001: begin fwd_high = 2'd2; fwd_low = 2'd1; end
            // 000 and 111 carry no rotor position
            default: code_valid = 1'b0;
        endcase
    end

    always_comb begin
        logic [1:0] high_idx;
        logic [1:0] low_idx;
        // Reverse rotation swaps which phase sources and which sinks current
        high_idx = direction ? fwd_low : fwd_high;
        low_idx  = direction ? fwd_high : fwd_low;
        for (int j = 0; j < bldc_pkg::NUM_PHASES; j++) begin
            cmd[j].drive   = code_valid && (high_idx == 2'(j));
            // Third phase is left floating to sense back EMF
            cmd[j].float_z = !code_valid || ((high_idx != 2'(j)) && (low_idx != 2'(j)));
        end
    end

endmodule

// File: src/hall_fault_monitor.sv
/* Hall sensor monitor: reduced-rate sampling, steady 000 and 111 detection,
   reconnect detection and latched fault flags */

`timescale 1ns/1ns

module hall_fault_monitor #(
    parameter int STEADY_COUNT    = 8,
    parameter int SAMPLE_INTERVAL = 4
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   en,
    input  logic [2:0]             hall,
    input  logic                   in_poll,
    input  logic                   clear,
    output bldc_pkg::hall_status_t status
);

    localparam int TIMER_W = (SAMPLE_INTERVAL > 1) ? $clog2(SAMPLE_INTERVAL) : 1;
    localparam int CNT_W   = $clog2(STEADY_COUNT + 1);

    logic [TIMER_W-1:0] sample_timer;
    logic               sample_tick;
    logic [CNT_W-1:0]   low_cnt;
    logic [CNT_W-1:0]   high_cnt;
    logic [CNT_W-1:0]   reconnect_cnt;
    logic               code_valid;

    // Sample once per interval, at timer zero
    assign sample_tick = (sample_timer == '0);
    assign code_valid  = (hall != bldc_pkg::HALL_ALL_LOW) && (hall != bldc_pkg::HALL_ALL_HIGH);

    always_ff @(posedge clk) begin
        // Disabling the driver behaves as a soft reset of the monitor
        if (!rst_n || !en) begin
            sample_timer  <= '0;
            low_cnt       <= '0;
            high_cnt      <= '0;
            reconnect_cnt <= '0;
            status        <= '0;
        end else begin
            status.fault_event <= 1'b0;
            sample_timer <= (sample_timer == TIMER_W'(SAMPLE_INTERVAL - 1)) ? '0
                                                                           : sample_timer + 1'b1;
            if (clear) begin
                // Leaving the error state on 111 means the motor was unplugged
                status.disconnected <= 1'b1;
                status.hw_fault     <= 1'b0;
                low_cnt             <= '0;
                high_cnt            <= '0;
                reconnect_cnt       <= '0;
            end else if (low_cnt == CNT_W'(STEADY_COUNT)) begin
                status.hw_fault    <= 1'b1;
                status.fault_event <= 1'b1;
                low_cnt            <= '0;
            end else if (high_cnt == CNT_W'(STEADY_COUNT)) begin
                status.disconnected <= 1'b1;
                status.fault_event  <= 1'b1;
                high_cnt            <= '0;
            end else if (reconnect_cnt == CNT_W'(STEADY_COUNT)) begin
                // Sensor has read valid codes long enough while polling
                status.disconnected <= 1'b0;
                reconnect_cnt       <= '0;
            end else if (sample_tick) begin
                // Each counter only runs while its latch can still change
                low_cnt  <= (hall == bldc_pkg::HALL_ALL_LOW && !status.hw_fault)
                            ? low_cnt + 1'b1 : '0;
                high_cnt <= (hall == bldc_pkg::HALL_ALL_HIGH && !status.disconnected)
                            ? high_cnt + 1'b1 : '0;
                reconnect_cnt <= (in_poll && code_valid && status.disconnected
                                  && !status.hw_fault) ? reconnect_cnt + 1'b1 : '0;
            end
        end
    end

endmodule

// File: src/motor_mode_ctrl.sv
/* Motor mode FSM: stop, fixed-time startup ramp, run, hall polling and
   error, producing the applied duty cycle and the fault output */

`timescale 1ns/1ns

module motor_mode_ctrl #(
    parameter int DUTY_WIDTH  = 6,
    parameter int MIN_DUTY    = 2,
    parameter int RAMP_PERIOD = 64,
    parameter int RAMP_STEPS  = 8
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   en,
    input  logic [DUTY_WIDTH-1:0]  duty,
    input  bldc_pkg::hall_status_t status,
    input  logic [2:0]             hall,
    output logic [DUTY_WIDTH-1:0]  applied_duty,
    output logic                   in_poll,
    output logic                   clear,
    output logic                   fault
);

    localparam int RAMP_W = (RAMP_PERIOD > 1) ? $clog2(RAMP_PERIOD) : 1;
    localparam int STEP_W = $clog2(RAMP_STEPS + 1);
    localparam logic [DUTY_WIDTH-1:0] MIN_D = DUTY_WIDTH'(MIN_DUTY);

    bldc_pkg::motor_mode_e mode;
    logic [RAMP_W-1:0]     ramp_cnt;
    logic [STEP_W-1:0]     step_cnt;

    // The monitor only counts reconnect samples while we wait here
    assign in_poll = (mode == bldc_pkg::MODE_POLL_HALL);

    always_ff @(posedge clk) begin
        if (!rst_n || !en) begin
            mode         <= bldc_pkg::MODE_STOP;
            applied_duty <= '0;
            ramp_cnt     <= '0;
            step_cnt     <= '0;
            clear        <= 1'b0;
            fault        <= 1'b0;
        end else begin
            clear <= 1'b0;
            if (status.fault_event) begin
                // Cut drive at once; a disconnect is recoverable by polling
                applied_duty <= '0;
                mode <= status.disconnected ? bldc_pkg::MODE_POLL_HALL : bldc_pkg::MODE_ERR;
            end else begin
                case (mode)
                    bldc_pkg::MODE_STOP: begin
                        applied_duty <= '0;
                        ramp_cnt     <= '0;
                        step_cnt     <= '0;
                        if (duty > MIN_D) begin
                            applied_duty <= MIN_D;
                            mode         <= bldc_pkg::MODE_STARTUP;
                        end
                    end
                    bldc_pkg::MODE_STARTUP: begin
                        if (duty <= MIN_D) begin
                            applied_duty <= '0;
                            mode         <= bldc_pkg::MODE_STOP;
                        end else if (step_cnt == STEP_W'(RAMP_STEPS)) begin
                            applied_duty <= duty;
                            mode         <= bldc_pkg::MODE_RUN;
                        end else if (ramp_cnt == RAMP_W'(RAMP_PERIOD - 1)) begin
                            ramp_cnt <= '0;
                            step_cnt <= step_cnt + 1'b1;
                            // Hold at the request so the ramp never overshoots it
                            if (applied_duty < duty)
                                applied_duty <= applied_duty + 1'b1;
                        end else begin
                            ramp_cnt <= ramp_cnt + 1'b1;
                        end
                    end
                    bldc_pkg::MODE_RUN: begin
                        applied_duty <= duty;
                        if (duty <= MIN_D) begin
                            applied_duty <= '0;
                            mode         <= bldc_pkg::MODE_STOP;
                        end
                    end
                    bldc_pkg::MODE_POLL_HALL: begin
                        applied_duty <= '0;
                        if (!status.disconnected && !status.hw_fault)
                            mode <= bldc_pkg::MODE_STOP;
                    end
                    bldc_pkg::MODE_ERR: begin
                        applied_duty <= '0;
                        // Unplugging the motor is the way out of the error state
                        if (hall == bldc_pkg::HALL_ALL_HIGH) begin
                            fault <= 1'b0;
                            clear <= 1'b1;
                            mode  <= bldc_pkg::MODE_POLL_HALL;
                        end else begin
                            fault <= 1'b1;
                        end
                    end
                    default: mode <= bldc_pkg::MODE_STOP;
                endcase
            end
        end
    end

endmodule

// File: src/phase_pwm.sv
/* Single phase PWM generator with complementary gates, dead time and
   a float mode that turns both gates off */

`timescale 1ns/1ns

module phase_pwm #(
    parameter int DUTY_WIDTH = 6,
    parameter int MAX_DUTY   = 63,
    parameter int DEAD_TIME  = 2
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  bldc_pkg::phase_cmd_t  cmd,
    input  logic [DUTY_WIDTH-1:0] duty,
    output logic                  gate_high,
    output logic                  gate_low
);

    // Two extra bits keep the dead-time sums free of wrap-around
    localparam int EXT_W = DUTY_WIDTH + 2;

    logic [DUTY_WIDTH-1:0] period_cnt;
    logic [EXT_W-1:0]      cnt_dead;
    logic [EXT_W-1:0]      duty_ext;
    logic                  high_win;
    logic                  low_win;

    // ========================================================================
    // Period counter, 0 to MAX_DUTY
    // ========================================================================

    always_ff @(posedge clk) begin
        if (!rst_n)
            period_cnt <= '0;
        else if (period_cnt == DUTY_WIDTH'(MAX_DUTY))
            period_cnt <= '0;
        else
            period_cnt <= period_cnt + 1'b1;
    end

    // ========================================================================
    // Gate windows
    // ========================================================================

    assign cnt_dead = EXT_W'(period_cnt) + EXT_W'(DEAD_TIME);
    assign duty_ext = EXT_W'(duty);

    // High side ends DEAD_TIME before the duty edge
    assign high_win = (cnt_dead < duty_ext);
    // Low side starts at the duty edge and ends DEAD_TIME before the period wraps
    assign low_win  = (EXT_W'(period_cnt) >= duty_ext) && (cnt_dead <= EXT_W'(MAX_DUTY));

    always_comb begin
        if (cmd.float_z) begin
            gate_high = 1'b0;
            gate_low  = 1'b0;
        end else if (cmd.drive) begin
            gate_high = high_win;
            gate_low  = low_win;
        end else begin
            // Sinking phase keeps its low-side switch closed all period
            gate_high = 1'b0;
            gate_low  = 1'b1;
        end
    end

endmodule

// File: src/bldc_driver.sv
/* Top level BLDC driver: hall input sync, commutation decoder, fault monitor,
   mode FSM, three phase PWM generators and registered gate outputs */

`timescale 1ns/1ns

module bldc_driver #(
    parameter int DUTY_WIDTH      = 6,
    parameter int MAX_DUTY        = 63,
    parameter int MIN_DUTY        = 2,
    parameter int DEAD_TIME       = 2,
    parameter int STEADY_COUNT    = 8,
    parameter int SAMPLE_INTERVAL = 4,
    parameter int RAMP_PERIOD     = 64,
    parameter int RAMP_STEPS      = 8
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  en,
    input  logic [2:0]            hall,
    input  logic                  direction,
    input  logic [DUTY_WIDTH-1:0] duty,
    output logic [2:0]            phase_high,
    output logic [2:0]            phase_low,
    output logic                  connected,
    output logic                  fault
);

    logic [2:0]                                       hall_sync;
    bldc_pkg::phase_cmd_t [bldc_pkg::NUM_PHASES-1:0] cmd;
    bldc_pkg::hall_status_t                           status;
    logic [DUTY_WIDTH-1:0]                            applied_duty;
    logic                                             in_poll;
    logic                                             clear;
    logic [bldc_pkg::NUM_PHASES-1:0]                  pwm_high;
    logic [bldc_pkg::NUM_PHASES-1:0]                  pwm_low;

    // Hall lines come straight from the motor connector
    always_ff @(posedge clk) begin
        if (!rst_n)
            hall_sync <= '0;
        else
            hall_sync <= hall;
    end

    hall_commutation_decoder decoder_inst (
        .hall      (hall_sync),
        .direction (direction),
        .cmd       (cmd)
    );

    hall_fault_monitor #(
        .STEADY_COUNT    (STEADY_COUNT),
        .SAMPLE_INTERVAL (SAMPLE_INTERVAL)
    ) monitor_inst (
        .clk (clk), .rst_n (rst_n), .en (en),
        .hall (hall_sync), .in_poll (in_poll), .clear (clear), .status (status)
    );

    motor_mode_ctrl #(
        .DUTY_WIDTH (DUTY_WIDTH), .MIN_DUTY (MIN_DUTY),
        .RAMP_PERIOD (RAMP_PERIOD), .RAMP_STEPS (RAMP_STEPS)
    ) mode_ctrl_inst (
        .clk (clk), .rst_n (rst_n), .en (en), .duty (duty), .status (status),
        .hall (hall_sync), .applied_duty (applied_duty), .in_poll (in_poll),
        .clear (clear), .fault (fault)
    );

    for (genvar j = 0; j < bldc_pkg::NUM_PHASES; j++) begin : gen_phase
        phase_pwm #(
            .DUTY_WIDTH (DUTY_WIDTH), .MAX_DUTY (MAX_DUTY), .DEAD_TIME (DEAD_TIME)
        ) phase_pwm_inst (
            .clk (clk), .rst_n (rst_n), .cmd (cmd[j]), .duty (applied_duty),
            .gate_high (pwm_high[j]), .gate_low (pwm_low[j])
        );
    end

    // Gates go through one more flop so the pins see glitch-free levels
    always_ff @(posedge clk) begin
        if (!rst_n || !en) begin
            phase_high <= '0;
            phase_low  <= '0;
        end else begin
            phase_high <= pwm_high;
            phase_low  <= pwm_low;
        end
    end

    assign connected = ~status.disconnected;

endmodule

// File: tests/bldc_driver_props.sv
/* Bound checks on the BLDC driver: no shoot-through, fault cleared after
   disable, gates off after reset */

`timescale 1ns/1ns

module bldc_driver_props (
    input logic       clk,
    input logic       rst_n,
    input logic       en,
    input logic [2:0] phase_high,
    input logic [2:0] phase_low,
    input logic       fault
);

    // Number of property failures seen so far
    int fail_count = 0;

    // High and low switch of one leg must never conduct together
    gate_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
        (phase_high & phase_low) == 3'b000)
        else begin
            $error("Shoot-through: high and low gate of one phase both on");
            fail_count++;
        end

    // Dropping en clears the registered fault on the very next edge
    fault_off_when_disabled: assert property (@(posedge clk) !en |=> !fault)
        else begin
            $error("fault still set one cycle after en went low");
            fail_count++;
        end

    // Output flops clear under reset
    gates_off_after_reset: assert property (@(posedge clk)
        !rst_n |=> (phase_high == 3'b000 && phase_low == 3'b000))
        else begin
            $error("Gate outputs not cleared after reset");
            fail_count++;
        end

endmodule

// File: tests/bldc_driver_tb.sv
/* BLDC driver testbench: golden-file stimulus with commutation, startup ramp,
   stop, hall fault and enable checks, and a per-test report */

`timescale 1ns/1ns

module bldc_driver_tb;

    // DUT parameters match the top level defaults
    localparam int DUTY_WIDTH      = 6;
    localparam int MAX_DUTY        = 63;
    localparam int MIN_DUTY        = 2;
    localparam int DEAD_TIME       = 2;
    localparam int STEADY_COUNT    = 8;
    localparam int SAMPLE_INTERVAL = 4;
    localparam int RAMP_PERIOD     = 64;
    localparam int RAMP_STEPS      = 8;
    localparam int PERIOD          = MAX_DUTY + 1;
    // Hall sync and gate register add two cycles, the rest is margin
    localparam int SETTLE          = 4;
    localparam int RAMP_WINDOWS    = (RAMP_STEPS + 2) * RAMP_PERIOD / PERIOD;
    localparam int HOLD_LIMIT      = (STEADY_COUNT + 2) * SAMPLE_INTERVAL + 8;

    logic                  clk;
    logic                  rst_n;
    logic                  en;
    logic [2:0]            hall;
    logic                  direction;
    logic [DUTY_WIDTH-1:0] duty;
    logic [2:0]            phase_high;
    logic [2:0]            phase_low;
    logic                  connected;
    logic                  fault;

    // Fields of the current golden line
    string      test_name;
    string      op_name;
    int         en_v;
    int         dir_v;
    int         duty_v;
    int         count_v;
    int         conn_v;
    int         fault_v;
    logic [2:0] hall_v;
    logic [2:0] drv_m;
    logic [2:0] low_m;
    logic [2:0] flt_m;

    int error_count;
    int test_count;
    int pass_count;
    int high_cnt[3];
    int low_cnt[3];

    bldc_driver #(
        .DUTY_WIDTH (DUTY_WIDTH), .MAX_DUTY (MAX_DUTY), .MIN_DUTY (MIN_DUTY),
        .DEAD_TIME (DEAD_TIME), .STEADY_COUNT (STEADY_COUNT),
        .SAMPLE_INTERVAL (SAMPLE_INTERVAL), .RAMP_PERIOD (RAMP_PERIOD),
        .RAMP_STEPS (RAMP_STEPS)
    ) bldc_driver_inst (
        .clk (clk), .rst_n (rst_n), .en (en), .hall (hall), .direction (direction),
        .duty (duty), .phase_high (phase_high), .phase_low (phase_low),
        .connected (connected), .fault (fault)
    );

    bind bldc_driver bldc_driver_props props_inst (
        .clk (clk), .rst_n (rst_n), .en (en), .phase_high (phase_high),
        .phase_low (phase_low), .fault (fault)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // ========================================================================
    // Helpers
    // ========================================================================

    task automatic expect_eq(input string what, input int exp_v, input int act_v);
        assert (exp_v == act_v) else begin
            $display("** Error: test %s, %s: expected %0d, actual %0d",
                     test_name, what, exp_v, act_v);
            error_count++;
        end
    endtask

    // Index of the one phase set in a role mask
    function automatic int phase_of(input logic [2:0] mask);
        int idx;
        idx = -1;
        for (int j = 0; j < 3; j++)
            if (mask[j])
                idx = j;
        return idx;
    endfunction

    task automatic drive_inputs();
        @(posedge clk);
        en        <= en_v[0];
        hall      <= hall_v;
        direction <= dir_v[0];
        duty      <= DUTY_WIDTH'(duty_v);
    endtask

    // Counts gate-on cycles per phase over one full PWM period at mid-cycle
    task automatic measure_period();
        for (int j = 0; j < 3; j++) begin
            high_cnt[j] = 0;
            low_cnt[j]  = 0;
        end
        repeat (PERIOD) begin
            @(negedge clk);
            for (int j = 0; j < 3; j++) begin
                high_cnt[j] += int'(phase_high[j]);
                low_cnt[j]  += int'(phase_low[j]);
            end
        end
    endtask

    // ========================================================================
    // Test operations
    // ========================================================================

    // Driving phase pulses, sinking phase holds its low gate, third phase idles
    task automatic check_commutation();
        repeat (SETTLE) @(posedge clk);
        measure_period();
        for (int j = 0; j < 3; j++) begin
            if (drv_m[j]) begin
                expect_eq($sformatf("high cycles on driving phase %0d", j),
                          count_v, high_cnt[j]);
            end else if (low_m[j]) begin
                expect_eq($sformatf("low cycles on sinking phase %0d", j), PERIOD, low_cnt[j]);
                expect_eq($sformatf("high cycles on sinking phase %0d", j), 0, high_cnt[j]);
            end else if (flt_m[j]) begin
                expect_eq($sformatf("gate cycles on floating phase %0d", j), 0,
                          high_cnt[j] + low_cnt[j]);
            end
        end
    endtask

    // High-gate count per period must climb monotonically to the request
    task automatic follow_ramp();
        int  drv;
        int  prev;
        int  w;
        bit  reached;
        drv     = phase_of(drv_m);
        prev    = 0;
        reached = 1'b0;
        for (w = 0; w < RAMP_WINDOWS && !reached; w++) begin
            measure_period();
            if (w == 0) begin
                assert (high_cnt[drv] <= MIN_DUTY - DEAD_TIME + 1) else begin
                    $display(
                        "** Error: test %s, first high count: expected at most %0d, actual %0d",
                        test_name, MIN_DUTY - DEAD_TIME + 1, high_cnt[drv]);
                    error_count++;
                end
            end
            assert (high_cnt[drv] >= prev) else begin
                $display("** Error: test %s, high cycles fell: expected %0d or more, actual %0d",
                         test_name, prev, high_cnt[drv]);
                error_count++;
            end
            prev    = high_cnt[drv];
            reached = (high_cnt[drv] == count_v);
        end
        if (!reached) begin
            $display("Timeout in test %s: high-gate count never reached %0d within %0d periods",
                     test_name, count_v, RAMP_WINDOWS);
            error_count++;
        end
    endtask

    // Waits for the monitor and FSM to settle on the expected flags
    task automatic await_status();
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (!(int'(connected) == conn_v && int'(fault) == fault_v) && cycles < HOLD_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        if (cycles >= HOLD_LIMIT) begin
            $display("Timeout in test %s: connected and fault did not settle within %0d cycles",
                     test_name, HOLD_LIMIT);
            error_count++;
        end else begin
            // Settled flags must stay put, so a late FSM move still shows up
            repeat (SETTLE) @(negedge clk);
            expect_eq("connected", conn_v, int'(connected));
            expect_eq("fault", fault_v, int'(fault));
            // All phases floating means every gate must be off
            if (flt_m == 3'b111) begin
                expect_eq("phase_high", 0, int'(phase_high));
                expect_eq("phase_low", 0, int'(phase_low));
            end
        end
    endtask

    // en was driven low by drive_inputs; one cycle later it comes back
    task automatic pulse_enable();
        @(posedge clk);
        en <= 1'b1;
        @(negedge clk);
        expect_eq("fault", fault_v, int'(fault));
        expect_eq("connected", conn_v, int'(connected));
        expect_eq("phase_high", 0, int'(phase_high));
        expect_eq("phase_low", 0, int'(phase_low));
    endtask

    // ========================================================================
    // Main sequence
    // ========================================================================

    initial begin
        int    fd;
        int    n;
        int    errs_before;
        string line;
        // A valid hall code from the start keeps the 000 detector quiet
        en          = 1'b1;
        hall        = 3'b101;
        direction   = 1'b0;
        duty        = '0;
        rst_n       = 1'b0;
        error_count = 0;
        test_count  = 0;
        pass_count  = 0;
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        repeat (2) @(posedge clk);
        fd = $fopen("tests/bldc_golden.txt", "r");
        if (fd == 0) begin
            $display("Cannot open tests/bldc_golden.txt, no tests were run");
            error_count++;
        end else begin
            while (!$feof(fd)) begin
                n = $fgets(line, fd);
                if (n > 1 && line.getc(0) != "#") begin
                    n = $sscanf(line, "%s %s %d %b %d %d %b %b %b %d %d %d",
                                test_name, op_name, en_v, hall_v, dir_v, duty_v,
                                drv_m, low_m, flt_m, count_v, conn_v, fault_v);
                    if (n != 12) begin
                        $display("Golden line could not be parsed: %s", line);
                        error_count++;
                    end else begin
                        errs_before = error_count;
                        drive_inputs();
                        case (op_name)
                            "ramp":    follow_ramp();
                            "pwm":     check_commutation();
                            "hold":    await_status();
                            "enpulse": pulse_enable();
                            default: begin
                                $display("Test %s names an unknown operation %s",
                                         test_name, op_name);
                                error_count++;
                            end
                        endcase
                        test_count++;
                        if (error_count == errs_before) begin
                            pass_count++;
                            $display("Test %s: passed", test_name);
                        end else begin
                            $display("Test %s: FAILED", test_name);
                        end
                    end
                end
            end
            $fclose(fd);
        end
        // Bound property failures count against the run as well
        if (bldc_driver_inst.props_inst.fail_count != 0) begin
            $display("Bound assertions failed %0d times",
                     bldc_driver_inst.props_inst.fail_count);
            error_count += bldc_driver_inst.props_inst.fail_count;
        end
        $display("Summary: %0d tests, %0d passed, %0d failed, %0d errors",
                 test_count, pass_count, test_count - pass_count, error_count);
        if (error_count == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end

endmodule

// File: tests/bldc_golden.txt
# name op en hall dir duty drive_mask low_mask float_mask count connected fault
# Masks are binary with phase 0 as the rightmost bit; count is high-gate cycles per period
ramp_up      ramp    1 101 0 40 001 010 100 38 1 0
comm_101_fwd pwm     1 101 0 63 001 010 100 61 1 0
comm_101_rev pwm     1 101 1 63 010 001 100 61 1 0
comm_100_fwd pwm     1 100 0 63 001 100 010 61 1 0
comm_100_rev pwm     1 100 1 63 100 001 010 61 1 0
comm_110_fwd pwm     1 110 0 63 010 100 001 61 1 0
comm_110_rev pwm     1 110 1 63 100 010 001 61 1 0
comm_010_fwd pwm     1 010 0 63 010 001 100 61 1 0
comm_010_rev pwm     1 010 1 63 001 010 100 61 1 0
comm_011_fwd pwm     1 011 0 63 100 001 010 61 1 0
comm_011_rev pwm     1 011 1 63 001 100 010 61 1 0
comm_001_fwd pwm     1 001 0 63 100 010 001 61 1 0
comm_001_rev pwm     1 001 1 63 010 100 001 61 1 0
stop_low     pwm     1 101 0 2  001 010 100 0  1 0
disconnect   hold    1 111 0 0  000 000 111 0  0 0
reconnect    hold    1 101 0 0  001 010 100 0  1 0
hw_fault     hold    1 000 0 0  000 000 111 0  1 1
fault_clear  hold    1 111 0 0  000 000 111 0  0 0
reconnect_2  hold    1 101 0 0  001 010 100 0  1 0
hw_fault_2   hold    1 000 0 0  000 000 111 0  1 1
en_pulse     enpulse 0 000 0 0  000 000 111 0  1 0

// File: compile.f
src/bldc_pkg.sv
src/hall_commutation_decoder.sv
src/hall_fault_monitor.sv
src/motor_mode_ctrl.sv
src/phase_pwm.sv
src/bldc_driver.sv
tests/bldc_driver_props.sv
tests/bldc_driver_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build the BLDC driver testbench with Verilator, run it, and judge the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log
verilator --binary --timing --assert -Wno-fatal --top-module bldc_driver_tb \
    -f compile.f -o bldc_sim > build.log 2>&1 \
    || { echo "Verilator build failed, see build.log"; exit 1; }
./obj_dir/bldc_sim > sim.log 2>&1
grep -q "Done: no errors" sim.log \
    && echo "Simulation passed" \
    || { echo "Simulation failed, see sim.log"; exit 1; }
